/* hdl/sdadc_pkg.sv */
// Shared definitions for the two-channel sigma-delta decimation front end
// Filter order, decimation limits, register map and result emitter states
`default_nettype none

package sdadc_pkg;

    // Number of integrator stages and of comb stages in each CIC filter
    localparam int cic_order = 3;

    // Allowed range of the decimation exponent k, where the ratio is 2^k
    // Writes outside this range are clamped by the register block
    localparam int decim_log2_min = 6;
    localparam int decim_log2_max = 8;

    // Register map of the configuration block
    typedef enum logic [1:0] {
        // Bit 0 enables the modulator clock and the filters
        reg_control      = 2'd0,
        // Half period of the modulator clock minus one, in clock cycles
        reg_mod_divider  = 2'd1,
        // Decimation exponent k
        reg_decim_log2   = 2'd2,
        // Read only, counts decimation ticks since enable
        reg_sample_count = 2'd3
    } reg_address_t;

    // States of the result emitter
    typedef enum logic {
        emit_idle = 1'b0,
        emit_busy = 1'b1
    } emit_state_t;

endpackage

`default_nettype wire

/* hdl/sd_integrator.sv */
// CIC integrator section
// Samples one modulator bit stream on each modulator tick and feeds it
// through three cascaded accumulators that wrap modulo 2^processing_width
`default_nettype none
`timescale 1ns/1ps

module sd_integrator import sdadc_pkg::*; #(
    parameter int processing_width = 24
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        clear,
    input  logic                        mod_tick,
    input  logic                        sd_data,
    output logic [processing_width-1:0] integral
);

    logic [processing_width-1:0] accumulator [cic_order];
    logic [processing_width-1:0] stage_in [cic_order];

    // The first stage sums the raw bit, each later stage sums the stage before it
    always_comb begin
        stage_in[0] = {{(processing_width-1){1'b0}}, sd_data};
        for (int i = 1; i < cic_order; i++) begin
            stage_in[i] = accumulator[i-1];
        end
    end

    // All stages advance together on the tick
    // Each one adds the value its predecessor held before this tick
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            for (int i = 0; i < cic_order; i++) begin
                accumulator[i] <= '0;
            end
        end else if (mod_tick) begin
            for (int i = 0; i < cic_order; i++) begin
                // Overflow is harmless here, the comb undoes the wrap
                accumulator[i] <= accumulator[i] + stage_in[i];
            end
        end
    end

    // Output of the last accumulator feeds the comb section
    assign integral = accumulator[cic_order-1];

endmodule

`default_nettype wire

/* hdl/sd_comb.sv */
// CIC comb section
// Three cascaded differentiators running at the decimated rate
`default_nettype none
`timescale 1ns/1ps

module sd_comb import sdadc_pkg::*; #(
    parameter int processing_width = 24
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        clear,
    input  logic                        decim_tick,
    input  logic [processing_width-1:0] integral,
    output logic [processing_width-1:0] filtered
);

    // Previous input of each stage
    logic [processing_width-1:0] delayed [cic_order];
    // Current input of each stage
    logic [processing_width-1:0] stage_in [cic_order];
    // Difference at the end of the chain
    logic [processing_width-1:0] comb_out;

    // Stage 0 takes the integrator output and each later stage takes the
    // difference of the stage before it within the same period
    always_comb begin
        comb_out = integral;
        for (int i = 0; i < cic_order; i++) begin
            stage_in[i] = comb_out;
            // Modular subtraction recovers the true difference
            comb_out = comb_out - delayed[i];
        end
    end

    // Each stage computes x[n] - x[n-1] once per decimation period
    // Only the final difference is registered
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            for (int i = 0; i < cic_order; i++) begin
                delayed[i] <= '0;
            end
            filtered <= '0;
        end else if (decim_tick) begin
            for (int i = 0; i < cic_order; i++) begin
                delayed[i] <= stage_in[i];
            end
            filtered <= comb_out;
        end
    end

endmodule

`default_nettype wire

/* hdl/sd_channel.sv */
// One decimation channel
// CIC integrator and comb followed by an output stage that scales the
// filter value, removes mid-scale, saturates and sign-extends the result
`default_nettype none
`timescale 1ns/1ps

module sd_channel import sdadc_pkg::*; #(
    parameter int processing_width = 24,
    parameter int result_width     = 16,
    parameter int output_width     = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    mod_tick,
    input  logic                    decim_tick,
    input  logic                    sync,
    input  logic                    sd_data,
    input  logic [3:0]              decim_log2,
    output logic                    result_valid,
    output logic [output_width-1:0] result_data
);

    // Offset that turns the unsigned result into a signed one
    localparam logic [result_width-1:0] mid_scale = {1'b1, {(result_width-1){1'b0}}};

    logic [processing_width-1:0] integral;
    logic [processing_width-1:0] filtered;
    logic [processing_width-1:0] shifted;
    logic [5:0]                  shift_amount;
    logic                        decim_tick_d;
    logic [result_width:0]       unsigned_out;
    logic [result_width-1:0]     adc_value;

    sd_integrator #(
        .processing_width(processing_width)
    ) u_sd_integrator (
        .clock    (clock),
        .reset    (reset),
        .clear    (clear),
        .mod_tick (mod_tick),
        .sd_data  (sd_data),
        .integral (integral)
    );

    sd_comb #(
        .processing_width(processing_width)
    ) u_sd_comb (
        .clock      (clock),
        .reset      (reset),
        .clear      (clear),
        .decim_tick (decim_tick),
        .integral   (integral),
        .filtered   (filtered)
    );

    // CIC gain is 2^(3k), so dropping 3k-16 bits leaves full scale at bit 16
    assign shift_amount = 6'(cic_order * decim_log2 - result_width);
    assign shifted      = filtered >> shift_amount;

    // Comb output settles one cycle after decim_tick and is captured here
    always_ff @(posedge clock) begin
        if (reset) begin
            decim_tick_d <= 1'b0;
        end else begin
            decim_tick_d <= decim_tick;
        end
    end

    always_ff @(posedge clock) begin
        if (decim_tick_d) begin
            unsigned_out <= shifted[result_width:0];
        end
    end

    // Full scale input sets bit 16, which clips to the largest positive code
    always_comb begin
        if (unsigned_out[result_width]) begin
            adc_value = ~mid_scale;
        end else begin
            adc_value = unsigned_out[result_width-1:0] - mid_scale;
        end
    end

    // Result is presented for exactly the sync cycle
    assign result_valid = sync;
    assign result_data  = {{(output_width-result_width){adc_value[result_width-1]}}, adc_value};

endmodule

`default_nettype wire

/* hdl/sd_clock_gen.sv */
// Modulator clock and decimation timing generator
// Makes the off-chip modulator clock and the tick, decimation and sync strobes
`default_nettype none
`timescale 1ns/1ps

module sd_clock_gen (
    input  logic       clock,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] mod_divider,
    input  logic [3:0] decim_log2,
    output logic       mod_clock,
    output logic       mod_tick,
    output logic       decim_tick,
    output logic       sync
);

    logic [7:0] half_count;
    logic [7:0] half_last;
    logic [7:0] tick_count;
    logic [7:0] tick_last;
    logic       toggle;
    logic       falling;
    logic       sync_stage;

    // A divider of zero would stall the clock, so it runs as one
    assign half_last = (mod_divider == 8'd0) ? 8'd1 : mod_divider;
    // Last count of the decimation period, 2^k - 1
    assign tick_last = 8'((9'd1 << decim_log2) - 9'd1);

    // Comparing with >= recovers quickly if the divider shrinks mid period
    assign toggle  = (half_count >= half_last);
    assign falling = toggle && mod_clock;

    always_ff @(posedge clock) begin
        if (reset || !enable) begin
            half_count <= '0;
            tick_count <= '0;
            mod_clock  <= 1'b0;
            mod_tick   <= 1'b0;
            decim_tick <= 1'b0;
            sync_stage <= 1'b0;
            sync       <= 1'b0;
        end else begin
            // Tick lands in the same cycle that mod_clock goes low
            mod_tick   <= falling;
            decim_tick <= 1'b0;
            // Two stage delay gives the output stage time to settle
            sync_stage <= decim_tick;
            sync       <= sync_stage;
            if (toggle) begin
                half_count <= '0;
                mod_clock  <= ~mod_clock;
            end else begin
                half_count <= half_count + 8'd1;
            end
            // Every 2^k-th modulator tick is also a decimation tick
            if (falling) begin
                if (tick_count >= tick_last) begin
                    tick_count <= '0;
                    decim_tick <= 1'b1;
                end else begin
                    tick_count <= tick_count + 8'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sd_config_regs.sv */
// Configuration register block
// Holds enable, modulator divider and decimation exponent, counts decimation
// ticks, and returns register contents one cycle after a read
`default_nettype none
`timescale 1ns/1ps

module sd_config_regs import sdadc_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         reg_write,
    input  logic         reg_read,
    input  reg_address_t reg_address,
    input  logic [15:0]  reg_write_data,
    input  logic         decim_tick,
    output logic [15:0]  reg_read_data,
    output logic         enable,
    output logic [7:0]   mod_divider,
    output logic [3:0]   decim_log2
);

    logic [15:0] sample_count;
    logic [15:0] read_value;
    logic [3:0]  clamped_log2;

    // The whole write word is compared, so large values clamp instead of wrapping
    always_comb begin
        if (reg_write_data < 16'(decim_log2_min)) begin
            clamped_log2 = 4'(decim_log2_min);
        end else if (reg_write_data > 16'(decim_log2_max)) begin
            clamped_log2 = 4'(decim_log2_max);
        end else begin
            clamped_log2 = reg_write_data[3:0];
        end
    end

    // Read-back mux, registered below
    always_comb begin
        case (reg_address)
            reg_control:      read_value = {15'd0, enable};
            reg_mod_divider:  read_value = {8'd0, mod_divider};
            reg_decim_log2:   read_value = {12'd0, decim_log2};
            reg_sample_count: read_value = sample_count;
            default:          read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            enable        <= 1'b0;
            mod_divider   <= 8'd1;
            decim_log2    <= 4'(decim_log2_min);
            sample_count  <= '0;
            reg_read_data <= '0;
        end else begin
            if (reg_write) begin
                case (reg_address)
                    reg_control:     enable      <= reg_write_data[0];
                    reg_mod_divider: mod_divider <= reg_write_data[7:0];
                    reg_decim_log2:  decim_log2  <= clamped_log2;
                    // Sample count cannot be written
                    default:         ;
                endcase
            end
            // Count restarts from zero each time the block is enabled
            if (!enable) begin
                sample_count <= '0;
            end else if (decim_tick) begin
                sample_count <= sample_count + 16'd1;
            end
            if (reg_read) begin
                reg_read_data <= read_value;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sd_result_mux.sv */
// Result emitter
// Captures all channel results on sync and sends them out one per cycle,
// in channel order, each tagged with its channel number
`default_nettype none
`timescale 1ns/1ps

module sd_result_mux import sdadc_pkg::*; #(
    parameter int output_width = 32,
    parameter int channels     = 2
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [channels-1:0]                    result_valid,
    input  logic [channels-1:0][output_width-1:0]  result_data,
    output logic                                   out_valid,
    output logic [output_width-1:0]                out_data,
    output logic [$clog2(channels)-1:0]            out_dest
);

    localparam int dest_width = $clog2(channels);

    emit_state_t                          state;
    logic [dest_width-1:0]                index;
    logic [channels-1:0][output_width-1:0] held;
    logic                                 capture;

    // All channels share one sync, so any valid starts a burst
    assign capture = (state == emit_idle) && (|result_valid);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= emit_idle;
            index     <= '0;
            out_valid <= 1'b0;
            out_dest  <= '0;
        end else begin
            case (state)
                emit_idle: begin
                    out_valid <= capture;
                    if (capture) begin
                        // Channel 0 goes out directly in the next cycle
                        out_dest <= '0;
                        index    <= dest_width'(1);
                        state    <= emit_busy;
                    end
                end
                emit_busy: begin
                    out_valid <= 1'b1;
                    out_dest  <= index;
                    index     <= index + dest_width'(1);
                    if (index == dest_width'(channels - 1)) begin
                        state <= emit_idle;
                    end
                end
                default: state <= emit_idle;
            endcase
        end
    end

    // Data path follows the control above
    always_ff @(posedge clock) begin
        if (capture) begin
            held     <= result_data;
            out_data <= result_data[0];
        end else if (state == emit_busy) begin
            out_data <= held[index];
        end
    end

endmodule

`default_nettype wire

/* hdl/sd_adc_top.sv */
// Two-channel sigma-delta ADC decimation front end
// Register block, modulator clock generator, CIC channels and result emitter
`default_nettype none
`timescale 1ns/1ps

module sd_adc_top import sdadc_pkg::*; #(
    parameter int processing_width = 24,
    parameter int result_width     = 16,
    parameter int output_width     = 32,
    parameter int channels         = 2
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        reg_write,
    input  logic                        reg_read,
    input  reg_address_t                reg_address,
    input  logic [15:0]                 reg_write_data,
    output logic [15:0]                 reg_read_data,
    input  logic [channels-1:0]         sd_data,
    output logic                        mod_clock,
    output logic                        out_valid,
    output logic [output_width-1:0]     out_data,
    output logic [$clog2(channels)-1:0] out_dest
);

    logic                                  enable;
    logic                                  clear;
    logic [7:0]                            mod_divider;
    logic [3:0]                            decim_log2;
    logic                                  mod_tick;
    logic                                  decim_tick;
    logic                                  sync;
    logic [channels-1:0]                   result_valid;
    logic [channels-1:0][output_width-1:0] result_data;

    // Filters are held clear while the block is disabled
    assign clear = ~enable;

    sd_config_regs u_sd_config_regs (
        .clock          (clock),
        .reset          (reset),
        .reg_write      (reg_write),
        .reg_read       (reg_read),
        .reg_address    (reg_address),
        .reg_write_data (reg_write_data),
        .decim_tick     (decim_tick),
        .reg_read_data  (reg_read_data),
        .enable         (enable),
        .mod_divider    (mod_divider),
        .decim_log2     (decim_log2)
    );

    sd_clock_gen u_sd_clock_gen (
        .clock       (clock),
        .reset       (reset),
        .enable      (enable),
        .mod_divider (mod_divider),
        .decim_log2  (decim_log2),
        .mod_clock   (mod_clock),
        .mod_tick    (mod_tick),
        .decim_tick  (decim_tick),
        .sync        (sync)
    );

    // One channel per modulator input, all on the same timing strobes
    for (genvar ch = 0; ch < channels; ch++) begin : g_channel
        sd_channel #(
            .processing_width (processing_width),
            .result_width     (result_width),
            .output_width     (output_width)
        ) u_sd_channel (
            .clock        (clock),
            .reset        (reset),
            .clear        (clear),
            .mod_tick     (mod_tick),
            .decim_tick   (decim_tick),
            .sync         (sync),
            .sd_data      (sd_data[ch]),
            .decim_log2   (decim_log2),
            .result_valid (result_valid[ch]),
            .result_data  (result_data[ch])
        );
    end

    sd_result_mux #(
        .output_width (output_width),
        .channels     (channels)
    ) u_sd_result_mux (
        .clock        (clock),
        .reset        (reset),
        .result_valid (result_valid),
        .result_data  (result_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_dest     (out_dest)
    );

endmodule

`default_nettype wire

/* verif/sd_adc_props.sv */
// Protocol assertions for the decimation front end
// Bound into sd_adc_top to watch the result stream and the modulator clock
`default_nettype none
`timescale 1ns/1ps

module sd_adc_props (
    input logic clock,
    input logic reset,
    input logic enable,
    input logic mod_clock,
    input logic out_valid,
    input logic out_dest
);

    // Stream stays quiet while reset is held
    assert property (@(posedge clock) reset |=> !out_valid)
        else $error("out_valid high during reset");

    // A burst is two beats, never longer
    assert property (@(posedge clock) disable iff (reset)
        (out_valid && $past(out_valid)) |=> !out_valid)
        else $error("out_valid lasted more than two cycles");

    // Disabled block must not clock the modulators
    assert property (@(posedge clock) disable iff (reset) !enable |=> !mod_clock)
        else $error("mod_clock active while disabled");

    // Channel 0 leads each burst and channel 1 follows
    assert property (@(posedge clock) disable iff (reset) $rose(out_valid) |-> !out_dest)
        else $error("burst did not start with channel 0");
    assert property (@(posedge clock) disable iff (reset)
        $rose(out_valid) |=> (out_valid && out_dest))
        else $error("burst did not continue with channel 1");

endmodule

bind sd_adc_top sd_adc_props u_sd_adc_props (
    .clock     (clock),
    .reset     (reset),
    .enable    (enable),
    .mod_clock (mod_clock),
    .out_valid (out_valid),
    .out_dest  (out_dest[0])
);

`default_nettype wire

/* verif/sd_adc_tb.sv */
// Directed testbench for the two-channel sigma-delta decimation front end
// Models both modulators, programs the registers and checks the decimated
// results against the conversion rule
`default_nettype none
`timescale 1ns/1ps

module sd_adc_tb import sdadc_pkg::*; ();

    // Bursts dropped after every restart while the CIC pipeline fills
    localparam int settle_bursts  = 3;
    localparam int result_timeout = 8000;

    logic         clock = 1'b0;
    logic         reset = 1'b1;
    logic         reg_write = 1'b0;
    logic         reg_read = 1'b0;
    reg_address_t reg_address = reg_control;
    logic [15:0]  reg_write_data = '0;
    logic [15:0]  reg_read_data;
    logic [1:0]   sd_data = 2'b00;
    logic         mod_clock;
    logic         out_valid;
    logic [31:0]  out_data;
    logic [0:0]   out_dest;

    logic [3:0]   pattern [2];
    logic [1:0]   phase = 2'd0;
    int           cycle_count = 0;
    logic         failed = 1'b0;

    sd_adc_top u_sd_adc_top (
        .clock          (clock),
        .reset          (reset),
        .reg_write      (reg_write),
        .reg_read       (reg_read),
        .reg_address    (reg_address),
        .reg_write_data (reg_write_data),
        .reg_read_data  (reg_read_data),
        .sd_data        (sd_data),
        .mod_clock      (mod_clock),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_dest       (out_dest)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // New modulator bits appear shortly after each rising mod_clock edge
    always @(posedge mod_clock) begin
        #2;
        phase      = phase + 2'd1;
        sd_data[0] = pattern[0][phase];
        sd_data[1] = pattern[1][phase];
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    // Hard limit on simulated time in case a test stalls
    initial begin
        #2ms;
        report_failure("Simulation time limit reached");
    end

    // Every stimulus change happens 1 ns after a rising clock edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            failed = 1'b1;
            report_failure($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                     $time, name, $signed(actual), $signed(expected)));
        end
    endtask

    task automatic write_reg(input reg_address_t address, input logic [15:0] data);
        reg_write      = 1'b1;
        reg_address    = address;
        reg_write_data = data;
        next_cycle();
        reg_write = 1'b0;
    endtask

    // Read data is registered, so it is taken one cycle after the request
    task automatic read_reg(input reg_address_t address, output logic [15:0] data);
        reg_read    = 1'b1;
        reg_address = address;
        next_cycle();
        reg_read = 1'b0;
        data     = reg_read_data;
    endtask

    // Waits for one burst and returns both channel results and its start cycle
    task automatic wait_results(output logic [31:0] data0, output logic [31:0] data1,
                                output int start);
        int waited;
        waited = 0;
        while (!out_valid) begin
            if (waited >= result_timeout) begin
                report_failure("Timed out waiting for a result burst");
            end else begin
                next_cycle();
                waited++;
            end
        end
        start = cycle_count;
        check_value("out_dest", 32'(out_dest), 32'd0);
        data0 = out_data;
        next_cycle();
        check_value("out_valid", 32'(out_valid), 32'd1);
        check_value("out_dest", 32'(out_dest), 32'd1);
        data1 = out_data;
        next_cycle();
    endtask

    // n ones per 2^k block give n*2^(2k) >> (3k-16) minus mid-scale
    function automatic logic [31:0] expected_result(input logic [3:0] bits, input int k);
        longint ones;
        longint scaled;
        ones   = longint'($countones(bits)) * (longint'(1) << k) / 4;
        scaled = (ones << (2 * k)) >> (3 * k - 16);
        if (scaled >= 65536) begin
            return 32'(32767);
        end else begin
            return 32'(scaled - 32768);
        end
    endfunction

    // Disabling first clears the filters so every test starts from rest
    task automatic configure(input int k, input int divider,
                             input logic [3:0] bits0, input logic [3:0] bits1);
        write_reg(reg_control, 16'd0);
        write_reg(reg_mod_divider, 16'(divider));
        write_reg(reg_decim_log2, 16'(k));
        pattern[0] = bits0;
        pattern[1] = bits1;
        write_reg(reg_control, 16'd1);
    endtask

    // Drops the filling bursts, then checks two settled bursts
    task automatic check_settled(input int k, output int spacing);
        logic [31:0] data0;
        logic [31:0] data1;
        int          start;
        int          previous;
        previous = 0;
        for (int i = 0; i < settle_bursts; i++) begin
            wait_results(data0, data1, start);
        end
        for (int i = 0; i < 2; i++) begin
            previous = start;
            wait_results(data0, data1, start);
            check_value("channel 0 result", data0, expected_result(pattern[0], k));
            check_value("channel 1 result", data1, expected_result(pattern[1], k));
        end
        spacing = start - previous;
    endtask

    task automatic test_registers();
        logic [15:0] data;
        read_reg(reg_mod_divider, data);
        check_value("reset mod_divider", 32'(data), 32'd1);
        read_reg(reg_decim_log2, data);
        check_value("reset decim_log2", 32'(data), 32'd6);
        // Exponents outside 6 to 8 clamp to the nearest limit
        write_reg(reg_decim_log2, 16'd3);
        read_reg(reg_decim_log2, data);
        check_value("decim_log2 after 3", 32'(data), 32'd6);
        write_reg(reg_decim_log2, 16'd12);
        read_reg(reg_decim_log2, data);
        check_value("decim_log2 after 12", 32'(data), 32'd8);
        repeat (100) begin
            next_cycle();
            check_value("mod_clock", 32'(mod_clock), 32'd0);
        end
        read_reg(reg_sample_count, data);
        check_value("sample_count", 32'(data), 32'd0);
    endtask

    task automatic test_full_scale();
        int spacing;
        configure(6, 1, 4'b1111, 4'b0000);
        check_settled(6, spacing);
    endtask

    task automatic test_mid_patterns();
        int spacing;
        configure(7, 1, 4'b1010, 4'b1110);
        check_settled(7, spacing);
    endtask

    // Burst spacing is two half periods times 2^k modulator ticks
    task automatic test_slow_ratio();
        int spacing;
        configure(8, 3, 4'b1010, 4'b1110);
        check_settled(8, spacing);
        check_value("burst spacing", 32'(spacing), 32'(2 * 4 * 256));
    endtask

    task automatic test_reenable();
        logic [15:0] data;
        int          spacing;
        // Every burst since the last enable came from one decimation tick
        read_reg(reg_sample_count, data);
        check_value("sample_count while running", 32'(data), 32'(settle_bursts + 2));
        write_reg(reg_control, 16'd0);
        repeat (4) next_cycle();
        read_reg(reg_sample_count, data);
        check_value("sample_count after disable", 32'(data), 32'd0);
        write_reg(reg_control, 16'd1);
        check_settled(8, spacing);
    endtask

    initial begin
        pattern[0] = 4'b0000;
        pattern[1] = 4'b0000;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();
        test_registers();
        test_full_scale();
        test_mid_patterns();
        test_slow_ratio();
        test_reenable();
        if (!failed) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("One or more checks failed");
        end
    end

endmodule

`default_nettype wire

/* files.f */
hdl/sdadc_pkg.sv
hdl/sd_integrator.sv
hdl/sd_comb.sv
hdl/sd_channel.sv
hdl/sd_clock_gen.sv
hdl/sd_config_regs.sv
hdl/sd_result_mux.sv
hdl/sd_adc_top.sv
verif/sd_adc_props.sv
verif/sd_adc_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module sd_adc_tb -o sd_adc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sd_adc_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
